/* rtl/uart_pkg.sv */
package uart_pkg;

	localparam int DATA_W     = 8;
	localparam int ADDR_W     = 3;
	localparam int FIFO_CNT_W = 5;
	localparam int RX_ENTRY_W = DATA_W + 2;        // Data byte, parity error, framing error
	localparam int BIT_TICKS  = 16;
	localparam int TICK_W     = $clog2(BIT_TICKS);

	localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH     = 5'd16;
	localparam logic [TICK_W-1:0]     OVERSAMPLE_MID = 4'd7;
	localparam logic [TICK_W-1:0]     TICK_LAST      = TICK_W'(BIT_TICKS - 1);

	// Register map
	localparam logic [ADDR_W-1:0] REG_RBR_THR = 3'd0;  // DLL when DLAB is set
	localparam logic [ADDR_W-1:0] REG_IER     = 3'd1;  // DLM when DLAB is set
	localparam logic [ADDR_W-1:0] REG_IIR_FCR = 3'd2;
	localparam logic [ADDR_W-1:0] REG_LCR     = 3'd3;
	localparam logic [ADDR_W-1:0] REG_LSR     = 3'd5;
	localparam logic [ADDR_W-1:0] REG_SCR     = 3'd7;

	localparam int LCR_WLS  = 0;                   // Two bits wide
	localparam int LCR_PEN  = 3;
	localparam int LCR_EPS  = 4;
	localparam int LCR_DLAB = 7;

	localparam logic [DATA_W-1:0] LCR_RESET = 8'h03;
	localparam logic [DATA_W-1:0] LSR_RESET = 8'h60;   // THRE and TEMT

	localparam logic [3:0] IIR_NONE      = 4'b0001;
	localparam logic [3:0] IIR_RLS       = 4'b0110;
	localparam logic [3:0] IIR_RDA       = 4'b0100;
	localparam logic [3:0] IIR_THRE      = 4'b0010;
	localparam logic [3:0] IIR_FIFO_BITS = 4'b1100;

	// Bus ack sequencer
	localparam logic [1:0] BUS_IDLE = 2'd0;
	localparam logic [1:0] BUS_ACK  = 2'd1;
	localparam logic [1:0] BUS_REC  = 2'd2;

	// Serializer
	localparam logic [2:0] TX_IDLE   = 3'd0;
	localparam logic [2:0] TX_LOAD   = 3'd1;
	localparam logic [2:0] TX_START  = 3'd2;
	localparam logic [2:0] TX_DATA   = 3'd3;
	localparam logic [2:0] TX_PARITY = 3'd4;
	localparam logic [2:0] TX_STOP   = 3'd5;

	// Deserializer
	localparam logic [2:0] RX_IDLE   = 3'd0;
	localparam logic [2:0] RX_START  = 3'd1;
	localparam logic [2:0] RX_DATA   = 3'd2;
	localparam logic [2:0] RX_PARITY = 3'd3;
	localparam logic [2:0] RX_STOP   = 3'd4;

endpackage

/* rtl/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
	parameter int WIDTH = uart_pkg::DATA_W
) (
	input  logic                            clk,
	input  logic                            wb_rst_i,
	input  logic                            clear_i,
	input  logic                            push_i,
	input  logic [WIDTH-1:0]                data_i,
	input  logic                            pop_i,
	output logic [WIDTH-1:0]                data_o,
	output logic [uart_pkg::FIFO_CNT_W-1:0] count_o,
	output logic                            overrun_o,
	input  logic                            overrun_clr_i
);

	localparam int PTR_W = uart_pkg::FIFO_CNT_W - 1;

	logic [WIDTH-1:0] mem [uart_pkg::FIFO_DEPTH];
	logic [PTR_W-1:0] top_q;
	logic [PTR_W-1:0] bottom_q;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = count_o == uart_pkg::FIFO_DEPTH;
	assign do_pop  = pop_i & (count_o != '0);
	assign do_push = push_i & (~full | do_pop);   // A pop frees the slot
	assign data_o  = mem[bottom_q];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[top_q] <= data_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			top_q    <= '0;
			bottom_q <= '0;
			count_o  <= '0;
		end
		else if (clear_i)
		begin
			top_q    <= '0;
			bottom_q <= '0;
			count_o  <= '0;
		end
		else
		begin
			if (do_push)
				top_q <= top_q + 1'b1;
			if (do_pop)
				bottom_q <= bottom_q + 1'b1;
			if (do_push & ~do_pop)
				count_o <= count_o + 1'b1;
			else if (do_pop & ~do_push)
				count_o <= count_o - 1'b1;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			overrun_o <= 1'b0;
		else if (clear_i | overrun_clr_i)
			overrun_o <= 1'b0;
		else if (push_i & ~do_push)
			overrun_o <= 1'b1;                 // Sticky
	end

endmodule

/* rtl/uart_bus_port.sv */
`timescale 1ns/1ps

module uart_bus_port (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                        wb_we_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_cyc_i,
	input  logic [uart_pkg::DATA_W-1:0] rd_data_i,
	output logic                        wb_ack_o,
	output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
	output logic [uart_pkg::ADDR_W-1:0] reg_adr_o,
	output logic [uart_pkg::DATA_W-1:0] reg_dat_o,
	output logic                        reg_we_o,
	output logic                        reg_re_o
);

	logic       req_q;
	logic       we_q;
	logic [1:0] state_q;
	logic       take;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			req_q <= 1'b0;
		else
			req_q <= wb_stb_i & wb_cyc_i;
	end

	always_ff @(posedge clk)
	begin
		reg_adr_o <= wb_adr_i;
		reg_dat_o <= wb_dat_i;
		we_q      <= wb_we_i;
	end

	assign take     = req_q & (state_q == uart_pkg::BUS_IDLE);   // Only taken when idle
	assign reg_we_o = take & we_q;
	assign reg_re_o = take & ~we_q;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state_q  <= uart_pkg::BUS_IDLE;
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
		end
		else
		begin
			wb_ack_o <= take;
			if (take & ~we_q)
				wb_dat_o <= rd_data_i;
			case (state_q)
				uart_pkg::BUS_IDLE:
				begin
					if (take)
						state_q <= uart_pkg::BUS_ACK;
				end
				uart_pkg::BUS_ACK:
					state_q <= uart_pkg::BUS_REC;   // Stale stb still registered here
				default:
					state_q <= uart_pkg::BUS_IDLE;
			endcase
		end
	end

endmodule

/* rtl/uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter (
	input  logic                            clk,
	input  logic                            wb_rst_i,
	input  logic                            tick_i,
	input  logic [uart_pkg::DATA_W-1:0]     lcr_i,
	input  logic                            tf_push_i,
	input  logic [uart_pkg::DATA_W-1:0]     tf_data_i,
	input  logic                            tf_clear_i,
	output logic                            stx_pad_o,
	output logic [uart_pkg::FIFO_CNT_W-1:0] tf_count_o,
	output logic                            tx_idle_o
);

	logic [uart_pkg::DATA_W-1:0] tf_data;
	logic                        tf_valid;
	logic                        tf_ready;
	logic [2:0]                  state_q;
	logic [uart_pkg::TICK_W-1:0] tick_cnt_q;
	logic [2:0]                  bits_left_q;
	logic [uart_pkg::DATA_W-1:0] shift_q;
	logic                        parity_q;
	logic [uart_pkg::DATA_W-1:0] masked;
	logic [1:0]                  wls;
	logic                        bit_end;

	uart_fifo #(
		.WIDTH(uart_pkg::DATA_W)
	) tx_fifo_i (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.clear_i      (tf_clear_i),
		.push_i       (tf_push_i),
		.data_i       (tf_data_i),
		.pop_i        (tf_valid & tf_ready),
		.data_o       (tf_data),
		.count_o      (tf_count_o),
		.overrun_o    (),
		.overrun_clr_i(1'b0)
	);

	assign tf_valid  = tf_count_o != '0;
	assign tf_ready  = state_q == uart_pkg::TX_LOAD;
	assign tx_idle_o = state_q == uart_pkg::TX_IDLE;
	assign wls       = lcr_i[uart_pkg::LCR_WLS +: 2];
	assign masked    = tf_data & ({uart_pkg::DATA_W{1'b1}} >> (2'd3 - wls));
	assign bit_end   = tick_i & (tick_cnt_q == uart_pkg::TICK_LAST);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state_q     <= uart_pkg::TX_IDLE;
			tick_cnt_q  <= '0;
			bits_left_q <= '0;
			stx_pad_o   <= 1'b1;
		end
		else
		begin
			if (tx_idle_o | tf_ready)
				tick_cnt_q <= '0;
			else if (tick_i)
				tick_cnt_q <= tick_cnt_q + 1'b1;   // Wraps at the bit boundary
			case (state_q)
				uart_pkg::TX_START:  stx_pad_o <= 1'b0;
				uart_pkg::TX_DATA:   stx_pad_o <= shift_q[0];
				uart_pkg::TX_PARITY: stx_pad_o <= parity_q;
				default:             stx_pad_o <= 1'b1;
			endcase
			case (state_q)
				uart_pkg::TX_IDLE:
				begin
					if (tf_valid)
						state_q <= uart_pkg::TX_LOAD;
				end
				uart_pkg::TX_LOAD:
				begin
					bits_left_q <= 3'd4 + {1'b0, wls};
					state_q     <= tf_valid ? uart_pkg::TX_START : uart_pkg::TX_IDLE;
				end
				uart_pkg::TX_START:
				begin
					if (bit_end)
						state_q <= uart_pkg::TX_DATA;
				end
				uart_pkg::TX_DATA:
				begin
					if (bit_end)
					begin
						if (bits_left_q != '0)
							bits_left_q <= bits_left_q - 1'b1;
						else if (lcr_i[uart_pkg::LCR_PEN])
							state_q <= uart_pkg::TX_PARITY;
						else
							state_q <= uart_pkg::TX_STOP;
					end
				end
				uart_pkg::TX_PARITY:
				begin
					if (bit_end)
						state_q <= uart_pkg::TX_STOP;
				end
				default:
				begin
					if (bit_end)
						state_q <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (tf_ready)
		begin
			shift_q  <= masked;
			parity_q <= ^masked ^ ~lcr_i[uart_pkg::LCR_EPS];   // Even when EPS set
		end
		else if ((state_q == uart_pkg::TX_DATA) & bit_end)
			shift_q <= shift_q >> 1;                           // LSB first
	end

endmodule

/* rtl/uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver (
	input  logic                            clk,
	input  logic                            wb_rst_i,
	input  logic                            tick_i,
	input  logic [uart_pkg::DATA_W-1:0]     lcr_i,
	input  logic                            srx_pad_i,
	input  logic                            rf_pop_i,
	input  logic                            rf_clear_i,
	input  logic                            ovr_clr_i,
	output logic [uart_pkg::RX_ENTRY_W-1:0] rf_head_o,
	output logic [uart_pkg::FIFO_CNT_W-1:0] rf_count_o,
	output logic                            rf_overrun_o
);

	logic                            sync_q;
	logic                            rx_q;
	logic [2:0]                      state_q;
	logic [uart_pkg::TICK_W-1:0]     tick_cnt_q;
	logic [2:0]                      bits_left_q;
	logic [uart_pkg::DATA_W-1:0]     shift_q;
	logic                            par_acc_q;
	logic                            perr_q;
	logic                            rf_push_q;
	logic [uart_pkg::RX_ENTRY_W-1:0] entry_q;
	logic [1:0]                      wls;
	logic                            mid;
	logic                            bit_end;

	uart_fifo #(
		.WIDTH(uart_pkg::RX_ENTRY_W)
	) rx_fifo_i (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.clear_i      (rf_clear_i),
		.push_i       (rf_push_q),
		.data_i       (entry_q),
		.pop_i        (rf_pop_i),
		.data_o       (rf_head_o),
		.count_o      (rf_count_o),
		.overrun_o    (rf_overrun_o),
		.overrun_clr_i(ovr_clr_i)
	);

	assign wls     = lcr_i[uart_pkg::LCR_WLS +: 2];
	assign mid     = tick_i & (tick_cnt_q == uart_pkg::OVERSAMPLE_MID);
	assign bit_end = tick_i & (tick_cnt_q == uart_pkg::TICK_LAST);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			sync_q <= 1'b1;                    // Line idles high
			rx_q   <= 1'b1;
		end
		else
		begin
			sync_q <= srx_pad_i;
			rx_q   <= sync_q;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state_q     <= uart_pkg::RX_IDLE;
			tick_cnt_q  <= '0;
			bits_left_q <= '0;
			rf_push_q   <= 1'b0;
		end
		else
		begin
			rf_push_q <= (state_q == uart_pkg::RX_STOP) & mid;
			if (state_q == uart_pkg::RX_IDLE)
				tick_cnt_q <= '0;
			else if (tick_i)
				tick_cnt_q <= tick_cnt_q + 1'b1;
			case (state_q)
				uart_pkg::RX_IDLE:
				begin
					if (~rx_q)
						state_q <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START:
				begin
					bits_left_q <= 3'd4 + {1'b0, wls};
					if (mid & rx_q)
						state_q <= uart_pkg::RX_IDLE;   // Glitch, not a start bit
					else if (bit_end)
						state_q <= uart_pkg::RX_DATA;
				end
				uart_pkg::RX_DATA:
				begin
					if (bit_end)
					begin
						if (bits_left_q != '0)
							bits_left_q <= bits_left_q - 1'b1;
						else if (lcr_i[uart_pkg::LCR_PEN])
							state_q <= uart_pkg::RX_PARITY;
						else
							state_q <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_PARITY:
				begin
					if (bit_end)
						state_q <= uart_pkg::RX_STOP;
				end
				default:
				begin
					if (mid)
						state_q <= uart_pkg::RX_IDLE;   // Push at mid stop bit
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state_q)
			uart_pkg::RX_START:
			begin
				par_acc_q <= 1'b0;
				perr_q    <= 1'b0;
			end
			uart_pkg::RX_DATA:
			begin
				if (mid)
				begin
					shift_q   <= {rx_q, shift_q[uart_pkg::DATA_W-1:1]};
					par_acc_q <= par_acc_q ^ rx_q;
				end
			end
			uart_pkg::RX_PARITY:
			begin
				if (mid)
					perr_q <= par_acc_q ^ rx_q ^ ~lcr_i[uart_pkg::LCR_EPS];
			end
			uart_pkg::RX_STOP:
			begin
				if (mid)
					entry_q <= {shift_q >> (2'd3 - wls), perr_q, ~rx_q};   // Right aligned
			end
			default:
			begin
				par_acc_q <= 1'b0;
			end
		endcase
	end

endmodule

/* rtl/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs (
	input  logic                            clk,
	input  logic                            wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0]     reg_adr_i,
	input  logic [uart_pkg::DATA_W-1:0]     reg_dat_i,
	input  logic                            reg_we_i,
	input  logic                            reg_re_i,
	input  logic [uart_pkg::RX_ENTRY_W-1:0] rf_head_i,
	input  logic [uart_pkg::FIFO_CNT_W-1:0] rf_count_i,
	input  logic                            rf_overrun_i,
	input  logic [uart_pkg::FIFO_CNT_W-1:0] tf_count_i,
	input  logic                            tx_idle_i,
	output logic [uart_pkg::DATA_W-1:0]     rd_data_o,
	output logic [uart_pkg::DATA_W-1:0]     lcr_o,
	output logic                            baud_tick_o,
	output logic                            tf_push_o,
	output logic                            rf_pop_o,
	output logic                            rf_clear_o,
	output logic                            tf_clear_o,
	output logic                            ovr_clr_o,
	output logic                            int_o
);

	localparam int DL_W = 2 * uart_pkg::DATA_W;

	logic [3:0]                      ier_q;
	logic [DL_W-1:0]                 dl_q;
	logic [DL_W-1:0]                 div_cnt_q;
	logic [uart_pkg::DATA_W-1:0]     scr_q;
	logic [1:0]                      fcr_trig_q;
	logic [uart_pkg::FIFO_CNT_W-1:0] trig_level;
	logic [uart_pkg::DATA_W-1:0]     lsr_q;
	logic [3:0]                      iir_q;
	logic                            dlab;
	logic                            thr_wr;
	logic                            fcr_wr;
	logic                            rbr_rd;
	logic                            iir_rd;
	logic                            rx_valid;
	logic                            tx_empty;
	logic                            rls_pnd;
	logic                            rda_pnd;
	logic                            thre_src;
	logic                            thre_src_q;
	logic                            thre_pnd_q;

	assign dlab      = lcr_o[uart_pkg::LCR_DLAB];
	assign thr_wr    = reg_we_i & (reg_adr_i == uart_pkg::REG_RBR_THR) & ~dlab;
	assign fcr_wr    = reg_we_i & (reg_adr_i == uart_pkg::REG_IIR_FCR);
	assign rbr_rd    = reg_re_i & (reg_adr_i == uart_pkg::REG_RBR_THR) & ~dlab;
	assign iir_rd    = reg_re_i & (reg_adr_i == uart_pkg::REG_IIR_FCR);
	assign ovr_clr_o = reg_re_i & (reg_adr_i == uart_pkg::REG_LSR) & lsr_q[1];
	assign rx_valid  = rf_count_i != '0;
	assign tx_empty  = tf_count_i == '0;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			lcr_o      <= uart_pkg::LCR_RESET;
			ier_q      <= '0;
			dl_q       <= '0;
			scr_q      <= '0;
			fcr_trig_q <= '0;
		end
		else if (reg_we_i)
		begin
			case (reg_adr_i)
				uart_pkg::REG_RBR_THR:
				begin
					if (dlab)
						dl_q[uart_pkg::DATA_W-1:0] <= reg_dat_i;
				end
				uart_pkg::REG_IER:
				begin
					if (dlab)
						dl_q[DL_W-1:uart_pkg::DATA_W] <= reg_dat_i;
					else
						ier_q <= reg_dat_i[3:0];
				end
				uart_pkg::REG_IIR_FCR: fcr_trig_q <= reg_dat_i[7:6];
				uart_pkg::REG_LCR:     lcr_o      <= reg_dat_i;
				uart_pkg::REG_SCR:     scr_q      <= reg_dat_i;
				default:               ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			tf_push_o  <= 1'b0;
			rf_pop_o   <= 1'b0;
			rf_clear_o <= 1'b0;
			tf_clear_o <= 1'b0;
		end
		else
		begin
			tf_push_o  <= thr_wr;
			rf_pop_o   <= rbr_rd;              // After the head was read out
			rf_clear_o <= fcr_wr & reg_dat_i[1];
			tf_clear_o <= fcr_wr & reg_dat_i[2];
		end
	end

	always_comb
	begin
		case (fcr_trig_q)
			2'd0:    trig_level = 5'd1;
			2'd1:    trig_level = 5'd4;
			2'd2:    trig_level = 5'd8;
			default: trig_level = 5'd14;
		endcase
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			div_cnt_q   <= '0;
			baud_tick_o <= 1'b0;
		end
		else if (dl_q == '0)
		begin
			div_cnt_q   <= '0;
			baud_tick_o <= 1'b0;
		end
		else if (div_cnt_q >= dl_q - 1'b1)
		begin
			div_cnt_q   <= '0;
			baud_tick_o <= 1'b1;
		end
		else
		begin
			div_cnt_q   <= div_cnt_q + 1'b1;
			baud_tick_o <= 1'b0;
		end
	end

	// Bit 4 is break and bit 7 the FIFO error summary, neither kept
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			lsr_q <= uart_pkg::LSR_RESET;
		else
			lsr_q <= {1'b0, tx_empty & tx_idle_i, tx_empty, 1'b0,
				rx_valid & rf_head_i[0], rx_valid & rf_head_i[1], rf_overrun_i, rx_valid};
	end

	assign rls_pnd  = ier_q[2] & (|lsr_q[3:1]);
	assign rda_pnd  = ier_q[0] & (rf_count_i >= trig_level);
	assign thre_src = ier_q[1] & tx_empty;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			thre_src_q <= 1'b0;
			thre_pnd_q <= 1'b0;
			iir_q      <= uart_pkg::IIR_NONE;
			int_o      <= 1'b0;
		end
		else
		begin
			thre_src_q <= thre_src;
			if (thr_wr | (iir_rd & (iir_q == uart_pkg::IIR_THRE)))
				thre_pnd_q <= 1'b0;
			else if (thre_src & ~thre_src_q)
				thre_pnd_q <= 1'b1;                // FIFO just drained
			else if (~ier_q[1])
				thre_pnd_q <= 1'b0;
			if (rls_pnd)
				iir_q <= uart_pkg::IIR_RLS;
			else if (rda_pnd)
				iir_q <= uart_pkg::IIR_RDA;
			else if (thre_pnd_q)
				iir_q <= uart_pkg::IIR_THRE;
			else
				iir_q <= uart_pkg::IIR_NONE;
			int_o <= rls_pnd | rda_pnd | thre_pnd_q;
		end
	end

	always_comb
	begin
		case (reg_adr_i)
			uart_pkg::REG_RBR_THR:
				rd_data_o = dlab ? dl_q[uart_pkg::DATA_W-1:0] :
					rf_head_i[uart_pkg::RX_ENTRY_W-1 -: uart_pkg::DATA_W];
			uart_pkg::REG_IER:
				rd_data_o = dlab ? dl_q[DL_W-1:uart_pkg::DATA_W] : {4'b0000, ier_q};
			uart_pkg::REG_IIR_FCR: rd_data_o = {uart_pkg::IIR_FIFO_BITS, iir_q};
			uart_pkg::REG_LCR:     rd_data_o = lcr_o;
			uart_pkg::REG_LSR:     rd_data_o = lsr_q;
			uart_pkg::REG_SCR:     rd_data_o = scr_q;
			default:               rd_data_o = '0;
		endcase
	end

endmodule

/* rtl/uart_top.sv */
`timescale 1ns/1ps

module uart_top (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                        wb_we_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_cyc_i,
	input  logic                        srx_pad_i,
	output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
	output logic                        wb_ack_o,
	output logic                        stx_pad_o,
	output logic                        int_o
);

	logic [uart_pkg::ADDR_W-1:0]     reg_adr;
	logic [uart_pkg::DATA_W-1:0]     reg_dat;
	logic                            reg_we;
	logic                            reg_re;
	logic [uart_pkg::DATA_W-1:0]     rd_data;
	logic [uart_pkg::DATA_W-1:0]     lcr;
	logic                            baud_tick;
	logic                            tf_push;
	logic                            tf_clear;
	logic [uart_pkg::FIFO_CNT_W-1:0] tf_count;
	logic                            tx_idle;
	logic                            rf_pop;
	logic                            rf_clear;
	logic                            ovr_clr;
	logic [uart_pkg::RX_ENTRY_W-1:0] rf_head;
	logic [uart_pkg::FIFO_CNT_W-1:0] rf_count;
	logic                            rf_overrun;

	uart_bus_port bus_port_i (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_stb_i (wb_stb_i),
		.wb_cyc_i (wb_cyc_i),
		.rd_data_i(rd_data),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o),
		.reg_adr_o(reg_adr),
		.reg_dat_o(reg_dat),
		.reg_we_o (reg_we),
		.reg_re_o (reg_re)
	);

	uart_regs regs_i (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.reg_adr_i   (reg_adr),
		.reg_dat_i   (reg_dat),
		.reg_we_i    (reg_we),
		.reg_re_i    (reg_re),
		.rf_head_i   (rf_head),
		.rf_count_i  (rf_count),
		.rf_overrun_i(rf_overrun),
		.tf_count_i  (tf_count),
		.tx_idle_i   (tx_idle),
		.rd_data_o   (rd_data),
		.lcr_o       (lcr),
		.baud_tick_o (baud_tick),
		.tf_push_o   (tf_push),
		.rf_pop_o    (rf_pop),
		.rf_clear_o  (rf_clear),
		.tf_clear_o  (tf_clear),
		.ovr_clr_o   (ovr_clr),
		.int_o       (int_o)
	);

	// THR data is the registered bus byte, still held when the push lands
	uart_transmitter transmitter_i (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.tick_i    (baud_tick),
		.lcr_i     (lcr),
		.tf_push_i (tf_push),
		.tf_data_i (reg_dat),
		.tf_clear_i(tf_clear),
		.stx_pad_o (stx_pad_o),
		.tf_count_o(tf_count),
		.tx_idle_o (tx_idle)
	);

	uart_receiver receiver_i (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.tick_i      (baud_tick),
		.lcr_i       (lcr),
		.srx_pad_i   (srx_pad_i),
		.rf_pop_i    (rf_pop),
		.rf_clear_i  (rf_clear),
		.ovr_clr_i   (ovr_clr),
		.rf_head_o   (rf_head),
		.rf_count_o  (rf_count),
		.rf_overrun_o(rf_overrun)
	);

endmodule

/* tb/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;

	localparam int          ROWS          = 12;
	localparam int          BURST         = 17;
	localparam int          BUS_TIMEOUT   = 20;
	localparam logic [7:0]  DIVISOR       = 8'd2;
	localparam int          BIT_CLKS      = uart_pkg::BIT_TICKS * DIVISOR;

	logic                        clk;
	logic                        wb_rst_i;
	logic [uart_pkg::ADDR_W-1:0] wb_adr_i;
	logic [uart_pkg::DATA_W-1:0] wb_dat_i;
	logic                        wb_we_i;
	logic                        wb_stb_i;
	logic                        wb_cyc_i;
	logic                        srx_pad_i;
	logic [uart_pkg::DATA_W-1:0] wb_dat_o;
	logic                        wb_ack_o;
	logic                        stx_pad_o;
	logic                        int_o;
	logic                        bang_sel;
	logic                        bang_line;
	logic [31:0]                 lcg_state;
	int                          checks;
	int                          errors;
	logic [7:0]                  tab_lcr  [ROWS];
	logic [7:0]                  tab_byte [ROWS];
	logic [7:0]                  tab_exp  [ROWS];
	logic [7:0]                  burst    [BURST];

	uart_top dut_i (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_stb_i (wb_stb_i),
		.wb_cyc_i (wb_cyc_i),
		.srx_pad_i(srx_pad_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.stx_pad_o(stx_pad_o),
		.int_o    (int_o)
	);

	assign srx_pad_i = bang_sel ? bang_line : stx_pad_o;   // Serial loop or bit-banger

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] word_mask(input int bits);
		return 8'hff >> (8 - bits);
	endfunction

	task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
		else
			$display("ok %s %h", name, actual);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic bus_access(input logic [uart_pkg::ADDR_W-1:0] adr, input logic we,
		input logic [7:0] dat, output logic [7:0] rd);
		int n;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_we_i  = we;
		wb_stb_i = 1'b1;
		wb_cyc_i = 1'b1;
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (!wb_ack_o && n < BUS_TIMEOUT);   // Ack of the previous access is still up at entry
		if (!wb_ack_o)
			report_timeout("bus ack");
		rd       = wb_dat_o;
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic bus_write(input logic [uart_pkg::ADDR_W-1:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_access(adr, 1'b1, dat, unused);
	endtask

	task automatic bus_read(input logic [uart_pkg::ADDR_W-1:0] adr, output logic [7:0] rd);
		bus_access(adr, 1'b0, 8'h00, rd);
	endtask

	// Polls LSR until the given bit is set
	task automatic wait_lsr(input int bit_pos, input int polls, output logic [7:0] lsr);
		int n;
		n = 0;
		do
		begin
			bus_read(uart_pkg::REG_LSR, lsr);
			n++;
		end
		while (!lsr[bit_pos] && n < polls);
		if (!lsr[bit_pos])
			report_timeout($sformatf("LSR bit %0d", bit_pos));
	endtask

	task automatic wait_int(input logic level, input int cycles, input string what);
		int n;
		n = 0;
		while (int_o !== level && n < cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (int_o !== level)
			report_timeout(what);
	endtask

	task automatic hold_bits(input int bits);
		repeat (bits * BIT_CLKS) @(posedge clk);
		#1;
	endtask

	task automatic send_frame(input logic [7:0] data, input int nbits, input logic with_par,
		input logic par_bit, input logic stop_bit);
		bang_line = 1'b0;                   // Start bit
		hold_bits(1);
		for (int i = 0; i < nbits; i++)
		begin
			bang_line = data[i];
			hold_bits(1);
		end
		if (with_par)
		begin
			bang_line = par_bit;
			hold_bits(1);
		end
		bang_line = stop_bit;
		hold_bits(1);
		bang_line = 1'b1;
	endtask

	initial
	begin
		logic [7:0] rd;
		logic [7:0] lsr;
		logic [7:0] par;
		logic [7:0] sample;
		clk       = 1'b0;
		wb_rst_i  = 1'b1;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		wb_we_i   = 1'b0;
		wb_stb_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		bang_sel  = 1'b0;
		bang_line = 1'b1;
		checks    = 0;
		errors    = 0;
		lcg_state = 32'he441a145;

		// All word lengths, each with parity off, odd and even
		for (int i = 0; i < ROWS; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			case (i / 4)
				0:       par = 8'h00;
				1:       par = 8'h08;
				default: par = 8'h18;
			endcase
			tab_lcr[i]  = {6'b000000, 2'(i % 4)} | par;
			tab_byte[i] = lcg_state[23:16];
			tab_exp[i]  = tab_byte[i] & word_mask(5 + i % 4);
		end

		repeat (3) @(posedge clk);
		#1;
		wb_rst_i = 1'b0;

		check("stx_reset", 8'h01, {7'b0000000, stx_pad_o});
		bus_read(uart_pkg::REG_LCR, rd);
		check("lcr_reset", 8'h03, rd);
		bus_read(uart_pkg::REG_IIR_FCR, rd);
		check("iir_reset", 8'hc1, rd);
		bus_read(uart_pkg::REG_LSR, rd);
		check("lsr_reset", 8'h60, rd);
		check("int_reset", 8'h00, {7'b0000000, int_o});

		bus_write(uart_pkg::REG_LCR, 8'h83);
		bus_write(uart_pkg::REG_RBR_THR, 8'h5a);
		bus_write(uart_pkg::REG_IER, 8'ha5);
		bus_read(uart_pkg::REG_RBR_THR, rd);
		check("dll_readback", 8'h5a, rd);
		bus_read(uart_pkg::REG_IER, rd);
		check("dlm_readback", 8'ha5, rd);
		bus_write(uart_pkg::REG_RBR_THR, DIVISOR);
		bus_write(uart_pkg::REG_IER, 8'h00);
		bus_write(uart_pkg::REG_LCR, 8'h03);
		bus_write(uart_pkg::REG_SCR, 8'h3c);
		bus_read(uart_pkg::REG_SCR, rd);
		check("scr_readback", 8'h3c, rd);
		bus_write(uart_pkg::REG_IER, 8'hc5);
		bus_read(uart_pkg::REG_IER, rd);
		check("ier_readback", 8'h05, rd);   // Upper nibble not kept
		bus_write(uart_pkg::REG_IER, 8'h00);

		for (int i = 0; i < ROWS; i++)
		begin
			bus_write(uart_pkg::REG_LCR, tab_lcr[i]);
			bus_write(uart_pkg::REG_RBR_THR, tab_byte[i]);
			wait_lsr(0, 200, lsr);
			check($sformatf("row%0d_lcr%h_pe_fe", i, tab_lcr[i]), 8'h00, lsr & 8'h0c);
			bus_read(uart_pkg::REG_RBR_THR, rd);
			check($sformatf("row%0d_lcr%h_data", i, tab_lcr[i]), tab_exp[i], rd);
		end

		// 8 bits, even parity, frames from the bit-banger
		bus_write(uart_pkg::REG_LCR, 8'h1b);
		bang_sel = 1'b1;
		send_frame(8'ha5, 8, 1'b1, ~(^8'ha5), 1'b1);
		wait_lsr(0, 200, lsr);
		check("parity_error", 8'h04, lsr & 8'h0c);
		bus_read(uart_pkg::REG_RBR_THR, rd);
		check("parity_frame_data", 8'ha5, rd);
		send_frame(8'h3c, 8, 1'b1, ^8'h3c, 1'b0);
		wait_lsr(0, 200, lsr);
		check("framing_error", 8'h08, lsr & 8'h0c);
		hold_bits(12);                      // Receiver settles on the idle line
		bang_sel = 1'b0;
		bus_write(uart_pkg::REG_IIR_FCR, 8'h06);
		bus_read(uart_pkg::REG_LSR, rd);
		check("lsr_after_clear", 8'h60, rd);

		bus_write(uart_pkg::REG_LCR, 8'h03);
		for (int i = 0; i < BURST; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			burst[i]  = lcg_state[23:16];
			bus_write(uart_pkg::REG_RBR_THR, burst[i]);
		end
		wait_lsr(1, 2000, lsr);
		check("overrun_set", 8'h02, lsr & 8'h02);
		bus_read(uart_pkg::REG_LSR, rd);
		check("overrun_cleared", 8'h00, rd & 8'h02);
		for (int i = 0; i < BURST - 1; i++)
		begin
			bus_read(uart_pkg::REG_RBR_THR, rd);
			check($sformatf("burst%0d", i), burst[i], rd);
		end

		bus_write(uart_pkg::REG_IIR_FCR, 8'h00);   // Trigger level 1
		bus_write(uart_pkg::REG_IER, 8'h01);
		lcg_state = lcg_next(lcg_state);
		sample    = lcg_state[23:16];
		bus_write(uart_pkg::REG_RBR_THR, sample);
		wait_int(1'b1, 800, "received data interrupt");
		check("int_rda_set", 8'h01, {7'b0000000, int_o});
		bus_read(uart_pkg::REG_IIR_FCR, rd);
		check("iir_rda", 8'hc4, rd);
		bus_read(uart_pkg::REG_RBR_THR, rd);
		check("rda_data", sample, rd);
		wait_int(1'b0, 10, "received data interrupt to clear");
		check("int_rda_cleared", 8'h00, {7'b0000000, int_o});
		bus_read(uart_pkg::REG_IIR_FCR, rd);
		check("iir_after_rbr", 8'hc1, rd);

		bus_write(uart_pkg::REG_IER, 8'h02);
		wait_int(1'b1, 20, "THRE interrupt on enable");
		bus_read(uart_pkg::REG_IIR_FCR, rd);
		check("iir_thre_enable", 8'hc2, rd);
		wait_int(1'b0, 10, "THRE interrupt to clear");
		check("int_thre_cleared", 8'h00, {7'b0000000, int_o});
		lcg_state = lcg_next(lcg_state);
		bus_write(uart_pkg::REG_RBR_THR, lcg_state[23:16]);
		wait_int(1'b1, 50, "THRE interrupt after drain");
		check("int_thre_drain", 8'h01, {7'b0000000, int_o});
		bus_read(uart_pkg::REG_IIR_FCR, rd);
		check("iir_thre_drain", 8'hc2, rd);
		wait_int(1'b0, 10, "THRE interrupt to clear after drain");
		check("int_thre_drain_cleared", 8'h00, {7'b0000000, int_o});

		$display("checks %0d, failures %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* uart_top.f */
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_bus_port.sv
rtl/uart_transmitter.sv
rtl/uart_receiver.sv
rtl/uart_regs.sv
rtl/uart_top.sv
tb/uart_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module uart_tb -f uart_top.f -o uart_sim
./obj_dir/uart_sim > sim.log
cat sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
else
	exit 1
fi
